//--- rtl/mm_ram_pkg.sv
// Shared types, memory map and test-control codes of the RAM wrapper.
// Peripheral addresses must lie above the RAM range, so the RAM byte
// address width stays at 24 bits or less.

package mm_ram_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;
  typedef logic [7:0]  byte_t;
  typedef logic [4:0]  irq_id_t;

  // byte lanes that make up one word
  localparam int unsigned NUM_LANES = 4;

  // mask bit and acknowledge id of the timer interrupt
  localparam irq_id_t TIMER_IRQ_ID = 5'd7;

  // values written to the test status register
  localparam word_t PASS_CODE = 32'd123456789;
  localparam word_t FAIL_CODE = 32'd1;

  // test-control pseudo-registers
  localparam word_t TEST_STATUS_ADDR = 32'h2000_0000;
  localparam word_t EXIT_ADDR        = 32'h2000_0004;
  localparam word_t HALT_ADDR        = 32'h2000_0010;

  // timer registers
  localparam word_t TIMER_MASK_ADDR  = 32'h1500_0000;
  localparam word_t TIMER_CNT_ADDR   = 32'h1500_0004;

  // where the data read word comes from
  typedef enum logic {
    RSP_RAM,
    RSP_ZERO
  } rsp_src_t;

endpackage

//--- rtl/mm_addr_decode.sv
// Combinational decoder for the data port.
// Every request is granted in its own cycle. Addresses below
// 2**RAM_ADDR_WIDTH go to the RAM; unmapped reads return zero and
// unmapped writes are dropped. Byte enables only affect RAM writes.

`timescale 1ns/10ps

module mm_addr_decode #(
  parameter int unsigned RAM_ADDR_WIDTH = 16
) (
  input  logic                      data_req_i,
  input  logic                      data_we_i,
  input  mm_ram_pkg::word_t         data_addr_i,
  input  mm_ram_pkg::word_t         data_wdata_i,
  input  mm_ram_pkg::be_t           data_be_i,

  output logic                      data_gnt_o,
  output logic                      lane_req_o,
  output mm_ram_pkg::be_t           lane_we_o,
  output logic [RAM_ADDR_WIDTH-3:0] ram_word_o,
  output mm_ram_pkg::rsp_src_t      rsp_src_o,

  output logic                      tests_passed_o,
  output logic                      tests_failed_o,
  output logic                      exit_valid_o,
  output mm_ram_pkg::word_t         exit_value_o,

  output logic                      timer_mask_we_o,
  output logic                      timer_cnt_we_o
);

  import mm_ram_pkg::*;

  logic ram_hit;
  logic wr_req;
  logic status_hit;
  logic exit_hit;
  logic halt_hit;

  // the RAM occupies the bottom of the address space
  assign ram_hit = (data_addr_i[$bits(word_t)-1:RAM_ADDR_WIDTH] == '0);
  assign wr_req  = data_req_i & data_we_i;

  assign status_hit = (data_addr_i == TEST_STATUS_ADDR);
  assign exit_hit   = (data_addr_i == EXIT_ADDR);
  assign halt_hit   = (data_addr_i == HALT_ADDR);

  // no wait states anywhere
  assign data_gnt_o = data_req_i;

  assign ram_word_o = data_addr_i[RAM_ADDR_WIDTH-1:2];

  always_comb begin
    lane_req_o = 1'b0;
    lane_we_o  = '0;
    rsp_src_o  = RSP_ZERO;

    if (ram_hit) begin
      rsp_src_o  = RSP_RAM;
      lane_req_o = data_req_i;
      if (wr_req) begin
        lane_we_o = data_be_i;
      end
    end
  end

  // test-control strobes, only in the write cycle
  always_comb begin
    tests_passed_o = 1'b0;
    tests_failed_o = 1'b0;
    exit_valid_o   = 1'b0;
    exit_value_o   = '0;

    if (wr_req && !ram_hit) begin
      if (status_hit) begin
        // other status values are ignored
        tests_passed_o = (data_wdata_i == PASS_CODE);
        tests_failed_o = (data_wdata_i == FAIL_CODE);
      end else if (exit_hit) begin
        exit_valid_o = 1'b1;
        exit_value_o = data_wdata_i;
      end else if (halt_hit) begin
        // halt exits with value zero
        exit_valid_o = 1'b1;
      end
    end
  end

  // timer register writes
  assign timer_mask_we_o = wr_req & !ram_hit & (data_addr_i == TIMER_MASK_ADDR);
  assign timer_cnt_we_o  = wr_req & !ram_hit & (data_addr_i == TIMER_CNT_ADDR);

endmodule

//--- rtl/ram_byte_lane.sv
// One byte of every RAM word, as a true dual-port array.
// Port A is read-only, port B reads and writes. Both reads are registered.
// A same-cycle read and write of one word returns the old byte.
// Contents are not initialised.

`timescale 1ns/10ps

module ram_byte_lane #(
  parameter int unsigned RAM_ADDR_WIDTH = 16
) (
  input  logic                      clk_i,

  input  logic                      a_req_i,
  input  logic [RAM_ADDR_WIDTH-3:0] a_word_i,
  output mm_ram_pkg::byte_t         a_rdata_o,

  input  logic                      b_req_i,
  input  logic                      b_we_i,
  input  logic [RAM_ADDR_WIDTH-3:0] b_word_i,
  input  mm_ram_pkg::byte_t         b_wdata_i,
  output mm_ram_pkg::byte_t         b_rdata_o
);

  import mm_ram_pkg::*;

  localparam int unsigned DEPTH = 2 ** (RAM_ADDR_WIDTH - 2);

  byte_t mem [DEPTH];

  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem[a_word_i];
    end
    if (b_req_i) begin
      b_rdata_o <= mem[b_word_i];
      if (b_we_i) begin
        mem[b_word_i] <= b_wdata_i;
      end
    end
  end

endmodule

//--- rtl/mm_rsp.sv
// Response stage for both ports.
// Grants follow the requests directly; rvalid comes one cycle later.
// Data read words are taken from the lanes or forced to zero, depending
// on the registered source. Read data is only meaningful with rvalid.

`timescale 1ns/10ps

module mm_rsp (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 instr_req_i,
  input  logic                 data_req_i,
  input  mm_ram_pkg::rsp_src_t rsp_src_i,

  input  mm_ram_pkg::byte_t [mm_ram_pkg::NUM_LANES-1:0] lane_a_rdata_i,
  input  mm_ram_pkg::byte_t [mm_ram_pkg::NUM_LANES-1:0] lane_b_rdata_i,

  output logic                 instr_gnt_o,
  output logic                 instr_rvalid_o,
  output mm_ram_pkg::word_t    instr_rdata_o,

  output logic                 data_rvalid_o,
  output mm_ram_pkg::word_t    data_rdata_o
);

  import mm_ram_pkg::*;

  rsp_src_t rsp_src_q;

  assign instr_gnt_o = instr_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rvalid_o <= 1'b0;
      data_rvalid_o  <= 1'b0;
      rsp_src_q      <= RSP_ZERO;
    end else begin
      instr_rvalid_o <= instr_req_i;
      data_rvalid_o  <= data_req_i;
      // source lines up with the registered lane bytes
      rsp_src_q      <= rsp_src_i;
    end
  end

  // lane 0 holds the least significant byte
  assign instr_rdata_o = lane_a_rdata_i;

  always_comb begin
    if (rsp_src_q == RSP_RAM) begin
      data_rdata_o = lane_b_rdata_i;
    end else begin
      data_rdata_o = '0;
    end
  end

endmodule

//--- rtl/mm_timer.sv
// Countdown timer with a maskable interrupt.
// A count of N raises the request N cycles after the load, if the mask
// bit TIMER_IRQ_ID is set. The request holds until acknowledged.
// Register writes stall the countdown and the acknowledge for that edge.

`timescale 1ns/10ps

module mm_timer (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                mask_we_i,
  input  logic                cnt_we_i,
  input  mm_ram_pkg::word_t   wdata_i,

  input  logic                irq_ack_i,
  input  mm_ram_pkg::irq_id_t irq_id_i,
  output logic                irq_timer_o
);

  import mm_ram_pkg::*;

  // only the timer bit of the mask is kept
  logic  mask_q;
  word_t cnt_q;
  logic  irq_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= 1'b0;
      cnt_q  <= '0;
      irq_q  <= 1'b0;
    end else if (mask_we_i) begin
      mask_q <= wdata_i[TIMER_IRQ_ID];
    end else if (cnt_we_i) begin
      cnt_q <= wdata_i;
    end else begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // expiry on the 1 to 0 step
      if (cnt_q == word_t'(1) && mask_q) begin
        irq_q <= 1'b1;
      end
      // acknowledge beats a same-edge expiry
      if (irq_ack_i && irq_id_i == TIMER_IRQ_ID) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign irq_timer_o = irq_q;

endmodule

//--- rtl/mm_ram.sv
// RAM wrapper for simulating a small RISC-V core.
// Instruction port is read-only, data port has byte enables. Both get a
// grant in the request cycle and rvalid one cycle later, with no stalls.
// RAM_ADDR_WIDTH is the RAM byte-address width, valid from 4 to 24.
// Instruction addresses are taken modulo the RAM size.

`timescale 1ns/10ps

module mm_ram #(
  parameter int unsigned RAM_ADDR_WIDTH = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      instr_req_i,
  input  logic [RAM_ADDR_WIDTH-1:0] instr_addr_i,
  output mm_ram_pkg::word_t         instr_rdata_o,
  output logic                      instr_rvalid_o,
  output logic                      instr_gnt_o,

  input  logic                      data_req_i,
  input  mm_ram_pkg::word_t         data_addr_i,
  input  logic                      data_we_i,
  input  mm_ram_pkg::be_t           data_be_i,
  input  mm_ram_pkg::word_t         data_wdata_i,
  output mm_ram_pkg::word_t         data_rdata_o,
  output logic                      data_rvalid_o,
  output logic                      data_gnt_o,

  input  mm_ram_pkg::irq_id_t       irq_id_i,
  input  logic                      irq_ack_i,
  output logic                      irq_timer_o,

  output logic                      tests_passed_o,
  output logic                      tests_failed_o,
  output logic                      exit_valid_o,
  output mm_ram_pkg::word_t         exit_value_o
);

  import mm_ram_pkg::*;

  logic                      lane_req;
  be_t                       lane_we;
  logic [RAM_ADDR_WIDTH-3:0] ram_word;
  rsp_src_t                  rsp_src;
  logic                      timer_mask_we;
  logic                      timer_cnt_we;

  byte_t [NUM_LANES-1:0]     lane_a_rdata;
  byte_t [NUM_LANES-1:0]     lane_b_rdata;

  mm_addr_decode #(
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) i_decode (
    .data_req_i      (data_req_i),
    .data_we_i       (data_we_i),
    .data_addr_i     (data_addr_i),
    .data_wdata_i    (data_wdata_i),
    .data_be_i       (data_be_i),
    .data_gnt_o      (data_gnt_o),
    .lane_req_o      (lane_req),
    .lane_we_o       (lane_we),
    .ram_word_o      (ram_word),
    .rsp_src_o       (rsp_src),
    .tests_passed_o  (tests_passed_o),
    .tests_failed_o  (tests_failed_o),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o),
    .timer_mask_we_o (timer_mask_we),
    .timer_cnt_we_o  (timer_cnt_we)
  );

  // one lane per byte position of the word
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    ram_byte_lane #(
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) i_lane (
      .clk_i     (clk_i),
      .a_req_i   (instr_req_i),
      .a_word_i  (instr_addr_i[RAM_ADDR_WIDTH-1:2]),
      .a_rdata_o (lane_a_rdata[i]),
      .b_req_i   (lane_req),
      .b_we_i    (lane_we[i]),
      .b_word_i  (ram_word),
      .b_wdata_i (data_wdata_i[8*i +: 8]),
      .b_rdata_o (lane_b_rdata[i])
    );
  end

  mm_rsp i_rsp (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .data_req_i     (data_req_i),
    .rsp_src_i      (rsp_src),
    .lane_a_rdata_i (lane_a_rdata),
    .lane_b_rdata_i (lane_b_rdata),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o)
  );

  mm_timer i_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mask_we_i   (timer_mask_we),
    .cnt_we_i    (timer_cnt_we),
    .wdata_i     (data_wdata_i),
    .irq_ack_i   (irq_ack_i),
    .irq_id_i    (irq_id_i),
    .irq_timer_o (irq_timer_o)
  );

endmodule

//--- dv/mm_ram_tb.sv
// Testbench for the RAM wrapper with a byte-level RAM model and a timer model.
// Only words that were fully written before are read back, because the
// lane memories start out unknown. Inputs change 0.5 ns after each rising
// edge and every access takes one step of one clock cycle.

`timescale 1ns/10ps

module mm_ram_tb;

  import mm_ram_pkg::*;

  localparam int unsigned RAM_ADDR_WIDTH = 16;
  localparam int unsigned RAM_BYTES      = 2 ** RAM_ADDR_WIDTH;
  localparam int unsigned NUM_WORDS      = 16;
  localparam int unsigned NUM_UNMAPPED   = 8;
  localparam int unsigned MAX_COUNT      = 20;

  // cycles per test, used for the run limit
  localparam int unsigned RESET_LEN = 5;
  localparam int unsigned RAM_LEN   = 3 * NUM_WORDS;
  localparam int unsigned FETCH_LEN = 2 * NUM_WORDS;
  localparam int unsigned UNMAP_LEN = 3 * NUM_UNMAPPED + 2;
  localparam int unsigned CTRL_LEN  = 6;
  localparam int unsigned TIMER_LEN = 2 * MAX_COUNT + 14;
  localparam int unsigned TIMEOUT_CYCLES =
    2 * (RESET_LEN + RAM_LEN + FETCH_LEN + UNMAP_LEN + CTRL_LEN + TIMER_LEN);

  logic                      clk_i;
  logic                      rst_ni;
  logic                      instr_req_i;
  logic [RAM_ADDR_WIDTH-1:0] instr_addr_i;
  word_t                     instr_rdata_o;
  logic                      instr_rvalid_o;
  logic                      instr_gnt_o;
  logic                      data_req_i;
  word_t                     data_addr_i;
  logic                      data_we_i;
  be_t                       data_be_i;
  word_t                     data_wdata_i;
  word_t                     data_rdata_o;
  logic                      data_rvalid_o;
  logic                      data_gnt_o;
  irq_id_t                   irq_id_i;
  logic                      irq_ack_i;
  logic                      irq_timer_o;
  logic                      tests_passed_o;
  logic                      tests_failed_o;
  logic                      exit_valid_o;
  word_t                     exit_value_o;

  // reference model state
  byte_t ram_model [RAM_BYTES];
  word_t model_mask;
  word_t model_cnt;
  logic  model_irq;

  logic [31:0] lfsr_state;
  word_t       addr_list [NUM_WORDS];
  int          check_count;
  int          error_count;
  int          cycle_count;

  mm_ram #(
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_rdata_o  (instr_rdata_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_gnt_o    (instr_gnt_o),
    .data_req_i     (data_req_i),
    .data_addr_i    (data_addr_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_wdata_i   (data_wdata_i),
    .data_rdata_o   (data_rdata_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_gnt_o     (data_gnt_o),
    .irq_id_i       (irq_id_i),
    .irq_ack_i      (irq_ack_i),
    .irq_timer_o    (irq_timer_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without reaching the end", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic word_t model_word(input logic [RAM_ADDR_WIDTH-1:0] byte_addr);
    int unsigned base;
    base = {byte_addr[RAM_ADDR_WIDTH-1:2], 2'b00};
    return {ram_model[base+3], ram_model[base+2], ram_model[base+1], ram_model[base]};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // one clock cycle on both ports, checked against the model
  task automatic step(input logic i_req, input logic [RAM_ADDR_WIDTH-1:0] i_addr,
                      input logic d_req, input logic d_we, input word_t d_addr,
                      input be_t d_be, input word_t d_wdata,
                      input logic ack, input irq_id_t ack_id);
    word_t       exp_instr;
    word_t       exp_data;
    logic        ram_hit;
    logic        wr;
    logic        exp_exit;
    int unsigned base;
    instr_req_i  = i_req;
    instr_addr_i = i_addr;
    data_req_i   = d_req;
    data_we_i    = d_we;
    data_addr_i  = d_addr;
    data_be_i    = d_be;
    data_wdata_i = d_wdata;
    irq_ack_i    = ack;
    irq_id_i     = ack_id;
    ram_hit   = (d_addr < word_t'(RAM_BYTES));
    wr        = d_req && d_we;
    exp_exit  = wr && (d_addr == EXIT_ADDR || d_addr == HALT_ADDR);
    exp_instr = model_word(i_addr);
    exp_data  = ram_hit ? model_word(d_addr[RAM_ADDR_WIDTH-1:0]) : '0;
    #1;
    check_bit("instr_gnt_o", instr_gnt_o, i_req);
    check_bit("data_gnt_o", data_gnt_o, d_req);
    check_bit("tests_passed_o", tests_passed_o,
              wr && d_addr == TEST_STATUS_ADDR && d_wdata == PASS_CODE);
    check_bit("tests_failed_o", tests_failed_o,
              wr && d_addr == TEST_STATUS_ADDR && d_wdata == FAIL_CODE);
    check_bit("exit_valid_o", exit_valid_o, exp_exit);
    if (exp_exit) begin
      check_word("exit_value_o", exit_value_o, (d_addr == EXIT_ADDR) ? d_wdata : '0);
    end
    // model state after the coming edge
    if (wr && ram_hit) begin
      base = {d_addr[RAM_ADDR_WIDTH-1:2], 2'b00};
      for (int i = 0; i < NUM_LANES; i++) begin
        if (d_be[i]) begin
          ram_model[base+i] = d_wdata[8*i +: 8];
        end
      end
    end
    if (wr && d_addr == TIMER_MASK_ADDR) begin
      model_mask = d_wdata;
    end else if (wr && d_addr == TIMER_CNT_ADDR) begin
      model_cnt = d_wdata;
    end else begin
      if (model_cnt == 1 && model_mask[TIMER_IRQ_ID]) begin
        model_irq = 1'b1;
      end
      if (model_cnt != 0) begin
        model_cnt = model_cnt - 1;
      end
      if (ack && ack_id == TIMER_IRQ_ID) begin
        model_irq = 1'b0;
      end
    end
    @(posedge clk_i);
    #0.5;
    check_bit("instr_rvalid_o", instr_rvalid_o, i_req);
    check_bit("data_rvalid_o", data_rvalid_o, d_req);
    if (i_req) begin
      check_word("instr_rdata_o", instr_rdata_o, exp_instr);
    end
    if (d_req && !d_we) begin
      check_word("data_rdata_o", data_rdata_o, exp_data);
    end
    check_bit("irq_timer_o", irq_timer_o, model_irq);
    instr_req_i = 1'b0;
    data_req_i  = 1'b0;
    irq_ack_i   = 1'b0;
  endtask

  task automatic idle();
    step(1'b0, '0, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  task automatic write_data(input word_t addr, input be_t be, input word_t wdata);
    step(1'b0, '0, 1'b1, 1'b1, addr, be, wdata, 1'b0, '0);
  endtask

  task automatic read_data(input word_t addr);
    step(1'b0, '0, 1'b1, 1'b0, addr, '0, '0, 1'b0, '0);
  endtask

  task automatic fetch(input logic [RAM_ADDR_WIDTH-1:0] addr);
    step(1'b1, addr, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  task automatic acknowledge(input irq_id_t id);
    step(1'b0, '0, 1'b0, 1'b0, '0, '0, '0, 1'b1, id);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, error_count - errs_before);
  endtask

  initial begin
    logic [31:0]               val;
    logic [31:0]               wdata;
    logic [RAM_ADDR_WIDTH-1:0] faddr;
    word_t                     uaddr;
    int                        errs;
    int                        count;
    int                        rise;
    irq_id_t                   other_id;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_addr_i  = '0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_wdata_i = '0;
    irq_id_i     = '0;
    irq_ack_i    = 1'b0;
    model_mask   = '0;
    model_cnt    = '0;
    model_irq    = 1'b0;
    lfsr_state   = 32'd79311;
    check_count  = 0;
    error_count  = 0;
    cycle_count  = 0;

    repeat (RESET_LEN) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    check_bit("instr_rvalid_o", instr_rvalid_o, 1'b0);
    check_bit("data_rvalid_o", data_rvalid_o, 1'b0);
    check_bit("irq_timer_o", irq_timer_o, 1'b0);

    // full words first so that every byte is known
    errs = error_count;
    for (int k = 0; k < NUM_WORDS; k++) begin
      take_bits(RAM_ADDR_WIDTH - 2, val);
      addr_list[k] = word_t'(val[RAM_ADDR_WIDTH-3:0]) << 2;
      take_bits(32, wdata);
      write_data(addr_list[k], 4'hF, wdata);
    end
    for (int k = 0; k < NUM_WORDS; k++) begin
      take_bits(32, wdata);
      take_bits(4, val);
      write_data(addr_list[k], val[3:0], wdata);
    end
    for (int k = 0; k < NUM_WORDS; k++) begin
      read_data(addr_list[k]);
    end
    report_test("ram write and read", errs);

    // even steps collide with a data write to the fetched word
    errs = error_count;
    for (int k = 0; k < NUM_WORDS; k++) begin
      take_bits(2, val);
      faddr = addr_list[k][RAM_ADDR_WIDTH-1:0] | val[1:0];
      take_bits(32, wdata);
      if (k % 2 == 0) begin
        step(1'b1, faddr, 1'b1, 1'b1, addr_list[k], 4'hF, wdata, 1'b0, '0);
      end else begin
        step(1'b1, faddr, 1'b1, 1'b0, addr_list[(k+1) % NUM_WORDS], '0, '0, 1'b0, '0);
      end
    end
    for (int k = 0; k < NUM_WORDS; k++) begin
      fetch(addr_list[k][RAM_ADDR_WIDTH-1:0]);
    end
    report_test("instruction fetch", errs);

    // unmapped writes alias a known RAM word in their low bits
    errs = error_count;
    for (int k = 0; k < NUM_UNMAPPED; k++) begin
      take_bits(12, val);
      uaddr = 32'h4000_0000 | ((val & 32'hFFF) << 16) | addr_list[k];
      take_bits(32, wdata);
      write_data(uaddr, 4'hF, wdata);
      read_data(uaddr);
      read_data(addr_list[k]);
    end
    read_data(TIMER_CNT_ADDR);
    read_data(EXIT_ADDR);
    report_test("unmapped access", errs);

    errs = error_count;
    write_data(TEST_STATUS_ADDR, 4'hF, PASS_CODE);
    write_data(TEST_STATUS_ADDR, 4'hF, FAIL_CODE);
    take_bits(32, wdata);
    write_data(TEST_STATUS_ADDR, 4'hF, wdata | 32'h8000_0000);
    take_bits(32, wdata);
    write_data(EXIT_ADDR, 4'hF, wdata);
    take_bits(32, wdata);
    write_data(HALT_ADDR, 4'hF, wdata);
    idle();
    report_test("test control", errs);

    errs = error_count;
    take_bits(32, wdata);
    write_data(TIMER_MASK_ADDR, 4'hF, wdata | (32'h1 << TIMER_IRQ_ID));
    take_bits(5, val);
    count = val % (MAX_COUNT - 1) + 2;
    write_data(TIMER_CNT_ADDR, 4'hF, word_t'(count));
    rise = 0;
    for (int k = 1; k <= count + 2; k++) begin
      idle();
      if (irq_timer_o === 1'b1 && rise == 0) begin
        rise = k;
      end
    end
    check_word("irq_timer_o rise cycle", word_t'(rise), word_t'(count));
    take_bits(5, val);
    other_id = (val[4:0] == TIMER_IRQ_ID) ? 5'd3 : val[4:0];
    acknowledge(other_id);
    check_bit("irq_timer_o after foreign ack", irq_timer_o, 1'b1);
    acknowledge(TIMER_IRQ_ID);
    check_bit("irq_timer_o after timer ack", irq_timer_o, 1'b0);
    idle();
    idle();
    // masked countdown must stay silent
    take_bits(32, wdata);
    write_data(TIMER_MASK_ADDR, 4'hF, wdata & ~(32'h1 << TIMER_IRQ_ID));
    take_bits(5, val);
    count = val % (MAX_COUNT - 1) + 2;
    write_data(TIMER_CNT_ADDR, 4'hF, word_t'(count));
    repeat (count + 4) begin
      idle();
      check_bit("irq_timer_o while masked", irq_timer_o, 1'b0);
    end
    report_test("timer", errs);

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- mm_ram.f
rtl/mm_ram_pkg.sv
rtl/mm_addr_decode.sv
rtl/ram_byte_lane.sv
rtl/mm_rsp.sv
rtl/mm_timer.sv
rtl/mm_ram.sv
dv/mm_ram_tb.sv
